// ==== source/axi_bridge_pkg.sv ====
package axi_bridge_pkg;

  // Lane and bank geometry
  localparam int NUM_LANES   = 2;
  localparam int LANE_W      = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;
  localparam int ADDR_W      = 32;
  localparam int DATA_W      = 32;
  localparam int STRB_W      = DATA_W / 8;
  localparam int BANK_WORDS  = 16;
  localparam int BANK_IDX_W  = $clog2(BANK_WORDS);
  // Word bits 1..0, then lane select, then bank index
  localparam int LANE_LSB    = 2;
  localparam int BANK_LSB    = LANE_LSB + LANE_W;
  localparam int ORDER_DEPTH = 4;
  localparam int ORDER_PTR_W = $clog2(ORDER_DEPTH);
  localparam int ORDER_CNT_W = $clog2(ORDER_DEPTH + 1);

  typedef enum logic [1:0] {
    OP_LW,
    OP_SB,
    OP_SH,
    OP_SW
  } mem_op_t;

  typedef enum logic [2:0] {
    IDLE,
    AR,
    R,
    AW,
    W,
    B,
    RSP
  } master_state_t;

  typedef struct packed {
    mem_op_t           op;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic              write;
    logic [DATA_W-1:0] rdata;
  } mem_rsp_t;

  typedef struct packed {
    logic [ADDR_W-1:0] awaddr;
  } axi_aw_t;

  typedef struct packed {
    logic [ADDR_W-1:0] araddr;
  } axi_ar_t;

  typedef struct packed {
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;
  } axi_w_t;

  typedef struct packed {
    logic [DATA_W-1:0] rdata;
  } axi_r_t;

endpackage

// ==== source/mem_dispatch.sv ====
`timescale 1ns/100ps

module mem_dispatch (
  input  logic                                  clk,
  input  logic                                  rstn,
  input  axi_bridge_pkg::mem_req_t              req,
  input  logic                                  req_valid,
  output logic                                  req_ready,
  output axi_bridge_pkg::mem_req_t              lane_req,
  output logic [axi_bridge_pkg::NUM_LANES-1:0]  lane_req_valid,
  input  logic [axi_bridge_pkg::NUM_LANES-1:0]  lane_req_ready,
  output logic [axi_bridge_pkg::LANE_W-1:0]     order_lane,
  output logic                                  order_valid,
  input  logic                                  order_pop
);
  import axi_bridge_pkg::*;

  logic [LANE_W-1:0]      lane;
  logic [LANE_W-1:0]      order_mem [ORDER_DEPTH];
  logic [ORDER_PTR_W-1:0] wr_ptr;
  logic [ORDER_PTR_W-1:0] rd_ptr;
  logic [ORDER_CNT_W-1:0] count;
  logic                   full;
  logic                   push;

  assign lane     = req.addr[LANE_LSB +: LANE_W];
  assign full     = (count == ORDER_CNT_W'(ORDER_DEPTH));
  assign lane_req = req;

  // Only the addressed lane sees valid, and only with room to record it
  always_comb begin
    lane_req_valid       = '0;
    lane_req_valid[lane] = req_valid & ~full;
  end

  assign req_ready   = lane_req_ready[lane] & ~full;
  assign push        = req_valid & req_ready;
  assign order_valid = (count != '0);
  assign order_lane  = order_mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      order_mem[wr_ptr] <= lane;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == ORDER_PTR_W'(ORDER_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (order_pop) begin
        rd_ptr <= (rd_ptr == ORDER_PTR_W'(ORDER_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + ORDER_CNT_W'(push) - ORDER_CNT_W'(order_pop);
    end
  end

endmodule

// ==== source/axi_master.sv ====
`timescale 1ns/100ps

module axi_master (
  input  logic                      clk,
  input  logic                      rstn,
  input  axi_bridge_pkg::mem_req_t  lane_req,
  input  logic                      lane_req_valid,
  output logic                      lane_req_ready,
  output axi_bridge_pkg::mem_rsp_t  lane_rsp,
  output logic                      lane_rsp_valid,
  input  logic                      lane_rsp_ready,
  output axi_bridge_pkg::axi_aw_t   aw,
  output logic                      aw_valid,
  input  logic                      aw_ready,
  output axi_bridge_pkg::axi_w_t    w,
  output logic                      w_valid,
  input  logic                      w_ready,
  input  logic                      b_valid,
  output logic                      b_ready,
  output axi_bridge_pkg::axi_ar_t   ar,
  output logic                      ar_valid,
  input  logic                      ar_ready,
  input  axi_bridge_pkg::axi_r_t    r,
  input  logic                      r_valid,
  output logic                      r_ready
);
  import axi_bridge_pkg::*;

  master_state_t     state;
  master_state_t     state_next;
  logic [ADDR_W-1:0] addr_q;
  logic [DATA_W-1:0] wdata_q;
  logic [STRB_W-1:0] wstrb_q;
  logic [DATA_W-1:0] wdata_d;
  logic [STRB_W-1:0] wstrb_d;
  logic              w_done;
  logic              accept;
  logic              w_hs;
  mem_rsp_t          rsp_q;

  assign accept = lane_req_valid & lane_req_ready;
  assign w_hs   = w_valid & w_ready;

  // Strobe from opcode and byte offset with data copied into every byte lane
  always_comb begin
    wstrb_d = '0;
    wdata_d = lane_req.wdata;
    case (lane_req.op)
      OP_SW: wstrb_d = {STRB_W{1'b1}};
      OP_SH: begin
        wstrb_d = lane_req.addr[1] ? 4'b1100 : 4'b0011;
        wdata_d = {2{lane_req.wdata[15:0]}};
      end
      OP_SB: begin
        wstrb_d = 4'b0001 << lane_req.addr[1:0];
        wdata_d = {4{lane_req.wdata[7:0]}};
      end
      default: wstrb_d = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q  <= lane_req.addr;
      wdata_q <= wdata_d;
      wstrb_q <= wstrb_d;
    end
    if (r_valid & r_ready) begin
      rsp_q <= '{write: 1'b0, rdata: r.rdata};
    end else if (b_valid & b_ready) begin
      rsp_q <= '{write: 1'b1, rdata: '0};
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state  <= IDLE;
      w_done <= 1'b0;
    end else begin
      state <= state_next;
      if (accept) begin
        w_done <= 1'b0;
      end else if (w_hs) begin
        w_done <= 1'b1;
      end
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      IDLE:    if (accept) state_next = (lane_req.op == OP_LW) ? AR : AW;
      AR:      if (ar_ready) state_next = R;
      R:       if (r_valid) state_next = RSP;
      // W may already be taken while AW still waits
      AW:      if (aw_ready) state_next = (w_done | w_hs) ? B : W;
      W:       if (w_ready) state_next = B;
      B:       if (b_valid) state_next = RSP;
      RSP:     if (lane_rsp_ready) state_next = IDLE;
      default: state_next = IDLE;
    endcase
  end

  assign lane_req_ready = (state == IDLE);
  assign lane_rsp_valid = (state == RSP);
  assign lane_rsp       = rsp_q;

  assign aw       = '{awaddr: addr_q};
  assign aw_valid = (state == AW);
  assign w        = '{wdata: wdata_q, wstrb: wstrb_q};
  assign w_valid  = ((state == AW) & ~w_done) | (state == W);
  assign b_ready  = (state == B);
  assign ar       = '{araddr: addr_q};
  assign ar_valid = (state == AR);
  assign r_ready  = (state == R);

endmodule

// ==== source/axi_sram_bank.sv ====
`timescale 1ns/100ps

module axi_sram_bank (
  input  logic                     clk,
  input  logic                     rstn,
  input  axi_bridge_pkg::axi_aw_t  aw,
  input  logic                     aw_valid,
  output logic                     aw_ready,
  input  axi_bridge_pkg::axi_w_t   w,
  input  logic                     w_valid,
  output logic                     w_ready,
  output logic                     b_valid,
  input  logic                     b_ready,
  input  axi_bridge_pkg::axi_ar_t  ar,
  input  logic                     ar_valid,
  output logic                     ar_ready,
  output axi_bridge_pkg::axi_r_t   r,
  output logic                     r_valid,
  input  logic                     r_ready
);
  import axi_bridge_pkg::*;

  logic [DATA_W-1:0]     mem [BANK_WORDS];
  logic [BANK_IDX_W-1:0] widx;
  logic [BANK_IDX_W-1:0] ridx;
  logic                  wr_en;
  logic                  rd_en;
  axi_r_t                r_q;

  assign widx = aw.awaddr[BANK_LSB +: BANK_IDX_W];
  assign ridx = ar.araddr[BANK_LSB +: BANK_IDX_W];

  // Address and data taken together and never with a B outstanding
  assign wr_en    = aw_valid & w_valid & ~b_valid;
  assign aw_ready = wr_en;
  assign w_ready  = wr_en;
  // Single port so a write in the same cycle holds off the read
  assign ar_ready = ~r_valid & ~wr_en;
  assign rd_en    = ar_valid & ar_ready;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      for (int i = 0; i < BANK_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else if (wr_en) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (w.wstrb[b]) begin
          mem[widx][8*b +: 8] <= w.wdata[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      r_q <= '{rdata: mem[ridx]};
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      b_valid <= 1'b0;
      r_valid <= 1'b0;
    end else begin
      if (wr_en) b_valid <= 1'b1;
      else if (b_ready) b_valid <= 1'b0;
      if (rd_en) r_valid <= 1'b1;
      else if (r_ready) r_valid <= 1'b0;
    end
  end

  assign r = r_q;

endmodule

// ==== source/rsp_merge.sv ====
`timescale 1ns/100ps

module rsp_merge (
  input  logic [axi_bridge_pkg::LANE_W-1:0]     order_lane,
  input  logic                                  order_valid,
  input  axi_bridge_pkg::mem_rsp_t              lane_rsp [axi_bridge_pkg::NUM_LANES],
  input  logic [axi_bridge_pkg::NUM_LANES-1:0]  lane_rsp_valid,
  output logic [axi_bridge_pkg::NUM_LANES-1:0]  lane_rsp_ready,
  output axi_bridge_pkg::mem_rsp_t              rsp,
  output logic                                  rsp_valid,
  input  logic                                  rsp_ready,
  output logic                                  order_pop
);
  import axi_bridge_pkg::*;

  // Only the oldest outstanding lane may hand over its response
  assign rsp       = lane_rsp[order_lane];
  assign rsp_valid = order_valid & lane_rsp_valid[order_lane];

  always_comb begin
    lane_rsp_ready = '0;
    if (order_valid) begin
      lane_rsp_ready[order_lane] = rsp_ready;
    end
  end

  assign order_pop = rsp_valid & rsp_ready;

endmodule

// ==== source/axi_bridge_top.sv ====
`timescale 1ns/100ps

module axi_bridge_top (
  input  logic                      clk,
  input  logic                      rstn,
  input  axi_bridge_pkg::mem_req_t  req,
  input  logic                      req_valid,
  output logic                      req_ready,
  output axi_bridge_pkg::mem_rsp_t  rsp,
  output logic                      rsp_valid,
  input  logic                      rsp_ready
);
  import axi_bridge_pkg::*;

  mem_req_t             lane_req;
  logic [NUM_LANES-1:0] lane_req_valid;
  logic [NUM_LANES-1:0] lane_req_ready;
  mem_rsp_t             lane_rsp [NUM_LANES];
  logic [NUM_LANES-1:0] lane_rsp_valid;
  logic [NUM_LANES-1:0] lane_rsp_ready;
  logic [LANE_W-1:0]    order_lane;
  logic                 order_valid;
  logic                 order_pop;

  axi_aw_t              aw [NUM_LANES];
  axi_w_t               w  [NUM_LANES];
  axi_ar_t              ar [NUM_LANES];
  axi_r_t               r  [NUM_LANES];
  logic [NUM_LANES-1:0] aw_valid;
  logic [NUM_LANES-1:0] aw_ready;
  logic [NUM_LANES-1:0] w_valid;
  logic [NUM_LANES-1:0] w_ready;
  logic [NUM_LANES-1:0] b_valid;
  logic [NUM_LANES-1:0] b_ready;
  logic [NUM_LANES-1:0] ar_valid;
  logic [NUM_LANES-1:0] ar_ready;
  logic [NUM_LANES-1:0] r_valid;
  logic [NUM_LANES-1:0] r_ready;

  mem_dispatch u_dispatch (
    .clk            (clk),
    .rstn           (rstn),
    .req            (req),
    .req_valid      (req_valid),
    .req_ready      (req_ready),
    .lane_req       (lane_req),
    .lane_req_valid (lane_req_valid),
    .lane_req_ready (lane_req_ready),
    .order_lane     (order_lane),
    .order_valid    (order_valid),
    .order_pop      (order_pop)
  );

  // One engine and one bank per interleaved lane
  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    axi_master u_master (
      .clk            (clk),
      .rstn           (rstn),
      .lane_req       (lane_req),
      .lane_req_valid (lane_req_valid[i]),
      .lane_req_ready (lane_req_ready[i]),
      .lane_rsp       (lane_rsp[i]),
      .lane_rsp_valid (lane_rsp_valid[i]),
      .lane_rsp_ready (lane_rsp_ready[i]),
      .aw             (aw[i]),
      .aw_valid       (aw_valid[i]),
      .aw_ready       (aw_ready[i]),
      .w              (w[i]),
      .w_valid        (w_valid[i]),
      .w_ready        (w_ready[i]),
      .b_valid        (b_valid[i]),
      .b_ready        (b_ready[i]),
      .ar             (ar[i]),
      .ar_valid       (ar_valid[i]),
      .ar_ready       (ar_ready[i]),
      .r              (r[i]),
      .r_valid        (r_valid[i]),
      .r_ready        (r_ready[i])
    );

    axi_sram_bank u_bank (
      .clk      (clk),
      .rstn     (rstn),
      .aw       (aw[i]),
      .aw_valid (aw_valid[i]),
      .aw_ready (aw_ready[i]),
      .w        (w[i]),
      .w_valid  (w_valid[i]),
      .w_ready  (w_ready[i]),
      .b_valid  (b_valid[i]),
      .b_ready  (b_ready[i]),
      .ar       (ar[i]),
      .ar_valid (ar_valid[i]),
      .ar_ready (ar_ready[i]),
      .r        (r[i]),
      .r_valid  (r_valid[i]),
      .r_ready  (r_ready[i])
    );
  end

  rsp_merge u_merge (
    .order_lane     (order_lane),
    .order_valid    (order_valid),
    .lane_rsp       (lane_rsp),
    .lane_rsp_valid (lane_rsp_valid),
    .lane_rsp_ready (lane_rsp_ready),
    .rsp            (rsp),
    .rsp_valid      (rsp_valid),
    .rsp_ready      (rsp_ready),
    .order_pop      (order_pop)
  );

endmodule

// ==== test/axi_bridge_properties.sv ====
`timescale 1ns/100ps

module axi_bridge_properties (
  input logic                      clk,
  input logic                      rstn,
  input axi_bridge_pkg::axi_aw_t   aw,
  input logic                      aw_valid,
  input logic                      aw_ready,
  input axi_bridge_pkg::axi_w_t    w,
  input logic                      w_valid,
  input logic                      w_ready,
  input axi_bridge_pkg::axi_ar_t   ar,
  input logic                      ar_valid,
  input logic                      ar_ready,
  input axi_bridge_pkg::mem_rsp_t  lane_rsp,
  input logic                      lane_rsp_valid,
  input logic                      lane_rsp_ready
);

  a_aw_hold: assert property (@(posedge clk) disable iff (!rstn)
    aw_valid && !aw_ready |=> aw_valid && $stable(aw))
    else $error("aw_valid dropped or awaddr changed before aw_ready");

  a_w_hold: assert property (@(posedge clk) disable iff (!rstn)
    w_valid && !w_ready |=> w_valid && $stable(w))
    else $error("w_valid dropped or write data changed before w_ready");

  a_ar_hold: assert property (@(posedge clk) disable iff (!rstn)
    ar_valid && !ar_ready |=> ar_valid && $stable(ar))
    else $error("ar_valid dropped or araddr changed before ar_ready");

  a_rsp_hold: assert property (@(posedge clk) disable iff (!rstn)
    lane_rsp_valid && !lane_rsp_ready |=> lane_rsp_valid && $stable(lane_rsp))
    else $error("lane response dropped or changed before lane_rsp_ready");

  // Engine leaves reset with every channel quiet
  a_reset_quiet: assert property (@(posedge clk)
    $rose(rstn) |-> !(aw_valid || w_valid || ar_valid || lane_rsp_valid))
    else $error("valid high right after reset");

endmodule

bind axi_master axi_bridge_properties u_props (
  .clk            (clk),
  .rstn           (rstn),
  .aw             (aw),
  .aw_valid       (aw_valid),
  .aw_ready       (aw_ready),
  .w              (w),
  .w_valid        (w_valid),
  .w_ready        (w_ready),
  .ar             (ar),
  .ar_valid       (ar_valid),
  .ar_ready       (ar_ready),
  .lane_rsp       (lane_rsp),
  .lane_rsp_valid (lane_rsp_valid),
  .lane_rsp_ready (lane_rsp_ready)
);

// ==== test/axi_bridge_tb.sv ====
`timescale 1ns/100ps

module axi_bridge_tb;
  import axi_bridge_pkg::*;

  localparam int NUM_OPS      = 300;
  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 2;
  localparam int IDLE_CYCLES  = 4;
  localparam int TAIL_CYCLES  = 8;
  // Per-operation budget plus the fixed cycles around the random run
  localparam int WATCHDOG_NS  = NUM_OPS * 40
                                + (RESET_CYCLES + IDLE_CYCLES + TAIL_CYCLES) * CLK_PERIOD;

  logic     clk;
  logic     rstn;
  mem_req_t req;
  logic     req_valid;
  logic     req_ready;
  mem_rsp_t rsp;
  logic     rsp_valid;
  logic     rsp_ready;

  integer               seed;
  logic [DATA_W-1:0]    model [32];
  mem_rsp_t             exp_q [$];
  // Lane of each outstanding request, oldest first
  logic [LANE_W-1:0]    lane_q [$];
  logic [NUM_LANES-1:0] busy;
  int                   gen_count;
  int                   accepted;
  int                   rsp_count;
  int                   stall_left;
  logic                 req_taken;

  axi_bridge_top u_axi_bridge_top (
    .clk       (clk),
    .rstn      (rstn),
    .req       (req),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .rsp       (rsp),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic fail_run(string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "simulation stopped at first error");
  endtask

  // Groups of eight alternate lanes before fully random traffic
  function automatic mem_req_t make_req(int n);
    mem_req_t    q;
    logic [31:0] r;
    int          slot;
    r       = $random(seed);
    slot    = 4 * (n % 8);
    q.wdata = $random(seed);
    q.op    = OP_LW;
    q.addr  = 32'(slot);
    case (n / 8)
      // Words not yet written read back zero
      0: q.addr = 32'(64 + slot);
      1: q.op = OP_SW;
      2: q.op = OP_LW;
      3: begin
        q.op   = n[0] ? OP_SH : OP_SB;
        q.addr = 32'(slot) + 32'(r[1:0]);
      end
      4: q.op = OP_LW;
      default: begin
        q.op   = mem_op_t'(r[1:0]);
        q.addr = {25'd0, r[8:2]};
      end
    endcase
    return q;
  endfunction

  task automatic apply_req(mem_req_t q);
    logic [4:0] idx;
    mem_rsp_t   e;
    idx     = q.addr[6:2];
    e       = '0;
    e.write = (q.op != OP_LW);
    case (q.op)
      OP_LW: e.rdata = model[idx];
      OP_SW: model[idx] = q.wdata;
      OP_SH: model[idx][{q.addr[1], 4'b0000} +: 16] = q.wdata[15:0];
      OP_SB: model[idx][{q.addr[1:0], 3'b000} +: 8] = q.wdata[7:0];
    endcase
    exp_q.push_back(e);
  endtask

  task automatic check_rsp(mem_rsp_t got);
    mem_rsp_t want;
    if (exp_q.size() == 0) begin
      fail_run($sformatf("response at %0t ns with no request outstanding", $time));
    end else begin
      want = exp_q.pop_front();
      if (got !== want) begin
        fail_run($sformatf("[FAIL] time %0t signal rsp got %0b/%08h expected %0b/%08h",
                           $time, got.write, got.rdata, want.write, want.rdata));
      end else begin
        rsp_count++;
      end
    end
  endtask

  task automatic check_ready(logic got, logic want);
    if (got !== want) begin
      fail_run($sformatf("[FAIL] time %0t signal req_ready got %0b expected %0b",
                         $time, got, want));
    end
  endtask

  task automatic check_no_rsp(logic got);
    if (got !== 1'b0) begin
      fail_run($sformatf("[FAIL] time %0t signal rsp_valid got %0b expected 0", $time, got));
    end
  endtask

  task automatic drive_inputs();
    logic [31:0] r;
    r = $random(seed);
    // A request stays up until it is taken
    if (!req_valid || req_taken) begin
      req_valid = 1'b0;
      if (gen_count < NUM_OPS && r[7:0] < 8'd205) begin
        req       = make_req(gen_count);
        req_valid = 1'b1;
        gen_count++;
      end
    end
    req_taken = 1'b0;
    // Mostly ready with an occasional longer stall
    if (stall_left > 0) begin
      rsp_ready = 1'b0;
      stall_left--;
    end else if (r[15:12] == 4'd0) begin
      rsp_ready  = 1'b0;
      stall_left = int'(r[18:16]);
    end else begin
      rsp_ready = (r[27:20] < 8'd179);
    end
  endtask

  // Older response retires before the request taken at the same edge
  task automatic sample_outputs();
    logic [LANE_W-1:0] lane;
    lane = req.addr[2];
    // A lane takes a new request only once its last response has left
    check_ready(req_ready, !busy[lane] && (exp_q.size() < ORDER_DEPTH));
    if (rsp_valid && rsp_ready) begin
      check_rsp(rsp);
      busy[lane_q.pop_front()] = 1'b0;
    end
    if (req_valid && req_ready) begin
      apply_req(req);
      busy[lane] = 1'b1;
      lane_q.push_back(lane);
      accepted++;
      req_taken = 1'b1;
    end
  endtask

  task automatic step_cycle();
    @(negedge clk);
    drive_inputs();
    #1;
    sample_outputs();
  endtask

  initial begin
    #(WATCHDOG_NS);
    fail_run($sformatf("timeout with %0d accepted and %0d of %0d responses back",
                       accepted, rsp_count, NUM_OPS));
  end

  initial begin
    seed       = 18;
    rstn       = 1'b0;
    req        = '0;
    req_valid  = 1'b0;
    rsp_ready  = 1'b0;
    req_taken  = 1'b0;
    busy       = '0;
    gen_count  = 0;
    accepted   = 0;
    rsp_count  = 0;
    stall_left = 0;
    for (int i = 0; i < 32; i++) begin
      model[i] = '0;
    end
    repeat (RESET_CYCLES) @(negedge clk);
    rstn = 1'b1;
    repeat (IDLE_CYCLES) begin
      @(negedge clk);
      #1;
      check_no_rsp(rsp_valid);
    end
    while (rsp_count < NUM_OPS) begin
      step_cycle();
    end
    // Nothing more may come out once every request is answered
    repeat (TAIL_CYCLES) begin
      step_cycle();
      check_no_rsp(rsp_valid);
    end
    $display("Test completed successfully");
    $finish;
  end

endmodule

// ==== sources.f ====
source/axi_bridge_pkg.sv
source/mem_dispatch.sv
source/axi_master.sv
source/axi_sram_bank.sv
source/rsp_merge.sv
source/axi_bridge_top.sv
test/axi_bridge_properties.sv
test/axi_bridge_tb.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := axi_bridge_tb
FILELIST  := sources.f
BUILD_DIR := obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Exit status of the simulation is the pass or fail result
run: compile
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
